/* include/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

//////////////////////////////
// Datapath
//////////////////////////////

`define EX_XLEN 32

//////////////////////////////
// Data cache geometry
//////////////////////////////

`define EX_DLINE_BYTES 16
`define EX_DCACHE_NSET 256
// Set index sits right above the line offset
`define EX_SET_LSB $clog2(`EX_DLINE_BYTES)
`define EX_SET_W $clog2(`EX_DCACHE_NSET)

//////////////////////////////
// Iterative units
//////////////////////////////

`define EX_MUL_STEPS 32
`define EX_DIV_STEPS 32

`endif

/* verilog/ex_pkg.sv */
package ex_pkg;

    typedef enum logic [5:0] {
        OP_NOP   = 6'h00,
        OP_ADD   = 6'h01,
        OP_SUB   = 6'h02,
        OP_SLT   = 6'h03,
        OP_SLTU  = 6'h04,
        OP_AND   = 6'h05,
        OP_OR    = 6'h06,
        OP_XOR   = 6'h07,
        OP_NOR   = 6'h08,
        OP_SLL   = 6'h09,
        OP_SRL   = 6'h0a,
        OP_SRA   = 6'h0b,
        OP_LUI   = 6'h0c,
        OP_PCADD = 6'h0d,
        OP_MUL   = 6'h10,
        OP_MULH  = 6'h11,
        OP_MULHU = 6'h12,
        OP_DIV   = 6'h18,
        OP_DIVU  = 6'h19,
        OP_MOD   = 6'h1a,
        OP_MODU  = 6'h1b,
        OP_LD_B  = 6'h20,
        OP_LD_H  = 6'h21,
        OP_LD_W  = 6'h22,
        OP_ST_B  = 6'h28,
        OP_ST_H  = 6'h29,
        OP_ST_W  = 6'h2a
    } ex_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        MUL_LO   = 2'd0,
        MUL_HI_S = 2'd1,
        MUL_HI_U = 2'd2
    } mul_kind_e;

    typedef enum logic [1:0] {
        DIV_S = 2'd0,
        DIV_U = 2'd1,
        MOD_S = 2'd2,
        MOD_U = 2'd3
    } div_kind_e;

    function automatic logic is_mul(ex_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHU};
    endfunction

    function automatic logic is_div(ex_op_e op);
        return op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
    endfunction

    function automatic logic is_load(ex_op_e op);
        return op inside {OP_LD_B, OP_LD_H, OP_LD_W};
    endfunction

    function automatic logic is_store(ex_op_e op);
        return op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    endfunction

    function automatic mem_size_e op_size(ex_op_e op);
        case (op)
            OP_LD_B, OP_ST_B: return SIZE_B;
            OP_LD_H, OP_ST_H: return SIZE_H;
            default:          return SIZE_W;
        endcase
    endfunction

endpackage

/* verilog/ex_alu.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module ex_alu (
    input  ex_pkg::ex_op_e       op_i,
    input  logic [`EX_XLEN-1:0]  src1_i,
    input  logic [`EX_XLEN-1:0]  src2_i,
    input  logic [`EX_XLEN-1:0]  imm_i,
    input  logic [`EX_XLEN-1:0]  pc_i,
    output logic [`EX_XLEN-1:0]  result_o
);
    import ex_pkg::*;

    logic [$clog2(`EX_XLEN)-1:0] shamt;
    logic                        lt_signed;
    logic                        lt_unsigned;

    assign shamt       = src2_i[$clog2(`EX_XLEN)-1:0];
    assign lt_signed   = $signed(src1_i) < $signed(src2_i);
    assign lt_unsigned = src1_i < src2_i;

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = src1_i + src2_i;
            end
            OP_SUB: begin
                result_o = src1_i - src2_i;
            end
            OP_SLT: begin
                result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            end
            OP_SLTU: begin
                result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            end
            OP_AND: begin
                result_o = src1_i & src2_i;
            end
            OP_OR: begin
                result_o = src1_i | src2_i;
            end
            OP_XOR: begin
                result_o = src1_i ^ src2_i;
            end
            OP_NOR: begin
                result_o = ~(src1_i | src2_i);
            end
            OP_SLL: begin
                result_o = src1_i << shamt;
            end
            OP_SRL: begin
                result_o = src1_i >> shamt;
            end
            OP_SRA: begin
                result_o = $signed(src1_i) >>> shamt;
            end
            // Upper immediate is already placed in src2
            OP_LUI: begin
                result_o = src2_i;
            end
            OP_PCADD: begin
                result_o = pc_i + src2_i;
            end
            // Effective address for loads and stores
            OP_LD_B, OP_LD_H, OP_LD_W, OP_ST_B, OP_ST_H, OP_ST_W: begin
                result_o = src1_i + imm_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* verilog/ex_mul_unit.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module ex_mul_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_i,
    input  ex_pkg::mul_kind_e    kind_i,
    input  logic [`EX_XLEN-1:0]  src1_i,
    input  logic [`EX_XLEN-1:0]  src2_i,
    output logic                 busy_o,
    output logic                 done_o,
    output logic [`EX_XLEN-1:0]  result_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(`EX_MUL_STEPS + 1);

    logic                   sign_mode;
    logic [`EX_XLEN-1:0]    mag1;
    logic [`EX_XLEN-1:0]    mag2;
    logic [2*`EX_XLEN-1:0]  mcand_q;
    logic [2*`EX_XLEN-1:0]  acc_q;
    logic [`EX_XLEN-1:0]    mplier_q;
    logic                   neg_q;
    mul_kind_e              kind_q;
    logic [CNT_W-1:0]       cnt_q;
    logic                   busy_q;
    logic                   done_q;
    logic [2*`EX_XLEN-1:0]  product;

    // Only the signed high word needs magnitudes, low word is sign agnostic
    assign sign_mode = (kind_i == MUL_HI_S);
    assign mag1 = (sign_mode && src1_i[`EX_XLEN-1]) ? -src1_i : src1_i;
    assign mag2 = (sign_mode && src2_i[`EX_XLEN-1]) ? -src2_i : src2_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(`EX_MUL_STEPS - 1)) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // Shift-add, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q  <= {{`EX_XLEN{1'b0}}, mag1};
            mplier_q <= mag2;
            acc_q    <= '0;
            neg_q    <= sign_mode && (src1_i[`EX_XLEN-1] ^ src2_i[`EX_XLEN-1]);
            kind_q   <= kind_i;
        end else if (busy_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product  = neg_q ? -acc_q : acc_q;
    assign result_o = (kind_q == MUL_LO) ? product[`EX_XLEN-1:0]
                                         : product[2*`EX_XLEN-1:`EX_XLEN];
    assign busy_o   = busy_q;
    assign done_o   = done_q;

endmodule

/* verilog/ex_div_unit.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module ex_div_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_i,
    input  ex_pkg::div_kind_e    kind_i,
    input  logic [`EX_XLEN-1:0]  dividend_i,
    input  logic [`EX_XLEN-1:0]  divisor_i,
    output logic                 busy_o,
    output logic                 done_o,
    output logic [`EX_XLEN-1:0]  result_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(`EX_DIV_STEPS + 1);

    logic                 sign_mode;
    logic [`EX_XLEN-1:0]  divisor_nz;
    logic [`EX_XLEN-1:0]  mag_a;
    logic [`EX_XLEN-1:0]  mag_b;
    logic [`EX_XLEN-1:0]  rem_q;
    logic [`EX_XLEN-1:0]  quo_q;
    logic [`EX_XLEN-1:0]  dsr_q;
    logic                 qneg_q;
    logic                 rneg_q;
    div_kind_e            kind_q;
    logic [CNT_W-1:0]     cnt_q;
    logic                 busy_q;
    logic                 done_q;
    logic [`EX_XLEN:0]    partial;
    logic                 fits;
    logic [`EX_XLEN-1:0]  quo_final;
    logic [`EX_XLEN-1:0]  rem_final;

    assign sign_mode  = (kind_i == DIV_S) || (kind_i == MOD_S);
    // Divide by zero behaves as divide by one
    assign divisor_nz = (divisor_i == '0) ? `EX_XLEN'(1) : divisor_i;
    assign mag_a = (sign_mode && dividend_i[`EX_XLEN-1]) ? -dividend_i : dividend_i;
    assign mag_b = (sign_mode && divisor_nz[`EX_XLEN-1]) ? -divisor_nz : divisor_nz;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(`EX_DIV_STEPS - 1)) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // Restoring step, next dividend bit comes out of the quotient register
    assign partial = {rem_q, quo_q[`EX_XLEN-1]};
    assign fits    = partial >= {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (start_i) begin
            rem_q  <= '0;
            quo_q  <= mag_a;
            dsr_q  <= mag_b;
            qneg_q <= sign_mode && (dividend_i[`EX_XLEN-1] ^ divisor_nz[`EX_XLEN-1]);
            rneg_q <= sign_mode && dividend_i[`EX_XLEN-1];
            kind_q <= kind_i;
        end else if (busy_q) begin
            rem_q <= fits ? `EX_XLEN'(partial - {1'b0, dsr_q}) : partial[`EX_XLEN-1:0];
            quo_q <= {quo_q[`EX_XLEN-2:0], fits};
        end
    end

    assign quo_final = qneg_q ? -quo_q : quo_q;
    assign rem_final = rneg_q ? -rem_q : rem_q;
    assign result_o  = (kind_q == DIV_S || kind_q == DIV_U) ? quo_final : rem_final;
    assign busy_o    = busy_q;
    assign done_o    = done_q;

endmodule

/* verilog/ex_mem_req.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module ex_mem_req (
    input  logic                 clk,
    input  logic                 rst,
    input  ex_pkg::ex_op_e       op_i,
    input  logic [`EX_XLEN-1:0]  base_i,
    input  logic [`EX_XLEN-1:0]  imm_i,
    input  logic [`EX_XLEN-1:0]  store_data_i,
    input  logic                 accept_i,
    input  logic                 dcache_ready_i,
    output logic                 issue_ok_o,
    output logic                 misalign_o,
    output logic [`EX_XLEN-1:0]  mem_addr_o,
    output logic                 dcache_req_o,
    output logic                 dcache_we_o,
    output logic [`EX_XLEN-1:0]  dcache_addr_o,
    output logic [3:0]           dcache_sel_o,
    output logic [`EX_XLEN-1:0]  dcache_wdata_o,
    output ex_pkg::mem_size_e    dcache_size_o
);
    import ex_pkg::*;

    logic [`EX_XLEN-1:0]   addr;
    logic                  is_mem;
    mem_size_e             size;
    logic [`EX_SET_W-1:0]  cur_set;
    logic                  last_valid_q;
    logic [`EX_SET_W-1:0]  last_set_q;
    logic                  prev_valid_q;
    logic [`EX_SET_W-1:0]  prev_set_q;
    logic                  set_stall;
    logic                  issue;

    assign addr    = base_i + imm_i;
    assign is_mem  = is_load(op_i) || is_store(op_i);
    assign size    = op_size(op_i);
    assign cur_set = addr[`EX_SET_LSB +: `EX_SET_W];

    assign misalign_o = is_mem && ((size == SIZE_H && addr[0]) ||
                                   (size == SIZE_W && addr[1:0] != 2'b00));

    //////////////////////////////
    // Same-set history
    //////////////////////////////

    // Last access stays live while the cache is not ready
    always_ff @(posedge clk) begin
        if (rst) begin
            last_valid_q <= 1'b0;
            last_set_q   <= '0;
        end else if (accept_i && is_mem) begin
            last_valid_q <= 1'b1;
            last_set_q   <= cur_set;
        end else if (dcache_ready_i) begin
            last_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_valid_q <= 1'b0;
            prev_set_q   <= '0;
        end else begin
            prev_valid_q <= last_valid_q;
            prev_set_q   <= last_set_q;
        end
    end

    assign set_stall = is_mem && ((last_valid_q && last_set_q == cur_set) ||
                                  (prev_valid_q && prev_set_q == cur_set));
    assign issue_ok_o = !is_mem || (dcache_ready_i && !set_stall);

    //////////////////////////////
    // Cache request
    //////////////////////////////

    assign issue = accept_i && is_mem && !misalign_o;

    always_comb begin
        dcache_req_o   = issue;
        dcache_we_o    = issue && is_store(op_i);
        dcache_addr_o  = '0;
        dcache_sel_o   = '0;
        dcache_wdata_o = '0;
        dcache_size_o  = SIZE_B;
        if (issue) begin
            dcache_addr_o = addr;
            dcache_size_o = size;
            case (size)
                SIZE_B: begin
                    dcache_sel_o   = 4'b0001 << addr[1:0];
                    dcache_wdata_o = {{(`EX_XLEN-8){1'b0}}, store_data_i[7:0]}
                                     << {addr[1:0], 3'b000};
                end
                SIZE_H: begin
                    dcache_sel_o   = 4'b0011 << addr[1:0];
                    dcache_wdata_o = {{(`EX_XLEN-16){1'b0}}, store_data_i[15:0]}
                                     << {addr[1:0], 3'b000};
                end
                default: begin
                    dcache_sel_o   = 4'b1111;
                    dcache_wdata_o = store_data_i;
                end
            endcase
        end
    end

    assign mem_addr_o = addr;

endmodule

/* verilog/ex_stage.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module ex_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  ex_pkg::ex_op_e       in_op_i,
    input  logic [`EX_XLEN-1:0]  in_src1_i,
    input  logic [`EX_XLEN-1:0]  in_src2_i,
    input  logic [`EX_XLEN-1:0]  in_imm_i,
    input  logic [`EX_XLEN-1:0]  in_pc_i,
    input  logic [4:0]           in_waddr_i,
    input  logic                 in_wreg_i,
    output logic                 out_valid_o,
    output logic [`EX_XLEN-1:0]  out_wdata_o,
    output logic [4:0]           out_waddr_o,
    output logic                 out_wreg_o,
    output logic                 out_data_ok_o,
    output logic                 out_misalign_o,
    output logic [`EX_XLEN-1:0]  out_mem_addr_o,
    output logic                 dcache_req_o,
    output logic                 dcache_we_o,
    output logic [`EX_XLEN-1:0]  dcache_addr_o,
    output logic [3:0]           dcache_sel_o,
    output logic [`EX_XLEN-1:0]  dcache_wdata_o,
    output ex_pkg::mem_size_e    dcache_size_o,
    input  logic                 dcache_ready_i
);
    import ex_pkg::*;

    logic                 op_mul;
    logic                 op_div;
    logic                 accept;
    logic                 issue_ok;
    logic                 unit_ready;
    logic                 misalign;
    logic [`EX_XLEN-1:0]  mem_addr;
    logic [`EX_XLEN-1:0]  alu_result;
    logic [`EX_XLEN-1:0]  mul_result;
    logic [`EX_XLEN-1:0]  div_result;
    logic [`EX_XLEN-1:0]  result;
    mul_kind_e            mul_kind;
    div_kind_e            div_kind;
    logic                 mul_start_q;
    logic                 mul_started_q;
    logic                 mul_busy;
    logic                 mul_done;
    logic                 div_start_q;
    logic                 div_started_q;
    logic                 div_busy;
    logic                 div_done;

    assign op_mul = is_mul(in_op_i);
    assign op_div = is_div(in_op_i);

    always_comb begin
        case (in_op_i)
            OP_MULH:  mul_kind = MUL_HI_S;
            OP_MULHU: mul_kind = MUL_HI_U;
            default:  mul_kind = MUL_LO;
        endcase
        case (in_op_i)
            OP_DIVU: div_kind = DIV_U;
            OP_MOD:  div_kind = MOD_S;
            OP_MODU: div_kind = MOD_U;
            default: div_kind = DIV_S;
        endcase
    end

    //////////////////////////////
    // Issue control
    //////////////////////////////

    // A unit result counts only once this instruction has started it
    assign unit_ready = op_mul ? (mul_started_q && mul_done) :
                        op_div ? (div_started_q && div_done) : 1'b1;
    assign in_ready_o = issue_ok && unit_ready && !rst;
    assign accept     = in_valid_i && in_ready_o;

    // One start pulse per instruction, the cycle after it shows up
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_start_q   <= 1'b0;
            mul_started_q <= 1'b0;
            div_start_q   <= 1'b0;
            div_started_q <= 1'b0;
        end else begin
            mul_start_q <= in_valid_i && op_mul && !mul_started_q && !mul_start_q && !mul_busy;
            div_start_q <= in_valid_i && op_div && !div_started_q && !div_start_q && !div_busy;
            if (accept) begin
                mul_started_q <= 1'b0;
                div_started_q <= 1'b0;
            end else begin
                mul_started_q <= mul_started_q || mul_start_q;
                div_started_q <= div_started_q || div_start_q;
            end
        end
    end

    ex_alu u_alu (
        .op_i     (in_op_i),
        .src1_i   (in_src1_i),
        .src2_i   (in_src2_i),
        .imm_i    (in_imm_i),
        .pc_i     (in_pc_i),
        .result_o (alu_result)
    );

    ex_mul_unit u_mul (
        .clk      (clk),
        .rst      (rst),
        .start_i  (mul_start_q),
        .kind_i   (mul_kind),
        .src1_i   (in_src1_i),
        .src2_i   (in_src2_i),
        .busy_o   (mul_busy),
        .done_o   (mul_done),
        .result_o (mul_result)
    );

    ex_div_unit u_div (
        .clk        (clk),
        .rst        (rst),
        .start_i    (div_start_q),
        .kind_i     (div_kind),
        .dividend_i (in_src1_i),
        .divisor_i  (in_src2_i),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .result_o   (div_result)
    );

    ex_mem_req u_mem_req (
        .clk            (clk),
        .rst            (rst),
        .op_i           (in_op_i),
        .base_i         (in_src1_i),
        .imm_i          (in_imm_i),
        .store_data_i   (in_src2_i),
        .accept_i       (accept),
        .dcache_ready_i (dcache_ready_i),
        .issue_ok_o     (issue_ok),
        .misalign_o     (misalign),
        .mem_addr_o     (mem_addr),
        .dcache_req_o   (dcache_req_o),
        .dcache_we_o    (dcache_we_o),
        .dcache_addr_o  (dcache_addr_o),
        .dcache_sel_o   (dcache_sel_o),
        .dcache_wdata_o (dcache_wdata_o),
        .dcache_size_o  (dcache_size_o)
    );

    assign result = op_mul ? mul_result :
                    op_div ? div_result : alu_result;

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_wdata_o    <= result;
            out_waddr_o    <= in_waddr_i;
            out_wreg_o     <= in_wreg_i;
            // Load data arrives later from the cache
            out_data_ok_o  <= !is_load(in_op_i);
            out_misalign_o <= misalign;
            out_mem_addr_o <= mem_addr;
        end
    end

endmodule

/* tb/ex_stage_tb.sv */
`timescale 1ns/100ps

module ex_stage_tb;
    import ex_pkg::*;

    localparam int MAX_VEC = 64;
    localparam int NCOL    = 13;
    localparam int TIMEOUT = 200;

    // Columns of the vector file after the test name
    localparam int C_OP     = 0;
    localparam int C_SRC1   = 1;
    localparam int C_SRC2   = 2;
    localparam int C_IMM    = 3;
    localparam int C_PC     = 4;
    localparam int C_WDATA  = 5;
    localparam int C_MIS    = 6;
    localparam int C_REQ    = 7;
    localparam int C_WE     = 8;
    localparam int C_ADDR   = 9;
    localparam int C_SEL    = 10;
    localparam int C_CWDATA = 11;
    localparam int C_HOLD   = 12;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    ex_op_e      in_op;
    logic [31:0] in_src1;
    logic [31:0] in_src2;
    logic [31:0] in_imm;
    logic [31:0] in_pc;
    logic [4:0]  in_waddr;
    logic        in_wreg;
    logic        out_valid;
    logic [31:0] out_wdata;
    logic [4:0]  out_waddr;
    logic        out_wreg;
    logic        out_data_ok;
    logic        out_misalign;
    logic [31:0] out_mem_addr;
    logic        dc_req;
    logic        dc_we;
    logic [31:0] dc_addr;
    logic [3:0]  dc_sel;
    logic [31:0] dc_wdata;
    mem_size_e   dc_size;
    logic        dc_ready;

    logic [31:0] vec_mem [MAX_VEC][NCOL];
    string       vec_name [MAX_VEC];
    int          num_vec;
    int          errors;
    int          test_errors;
    int          tests_failed;
    int          hold_left;
    int          req_count;
    integer      seed;
    bit          timed_out;
    string       cur_name;

    ex_stage uut (
        .clk            (clk),
        .rst            (rst),
        .in_valid_i     (in_valid),
        .in_ready_o     (in_ready),
        .in_op_i        (in_op),
        .in_src1_i      (in_src1),
        .in_src2_i      (in_src2),
        .in_imm_i       (in_imm),
        .in_pc_i        (in_pc),
        .in_waddr_i     (in_waddr),
        .in_wreg_i      (in_wreg),
        .out_valid_o    (out_valid),
        .out_wdata_o    (out_wdata),
        .out_waddr_o    (out_waddr),
        .out_wreg_o     (out_wreg),
        .out_data_ok_o  (out_data_ok),
        .out_misalign_o (out_misalign),
        .out_mem_addr_o (out_mem_addr),
        .dcache_req_o   (dc_req),
        .dcache_we_o    (dc_we),
        .dcache_addr_o  (dc_addr),
        .dcache_sel_o   (dc_sel),
        .dcache_wdata_o (dc_wdata),
        .dcache_size_o  (dc_size),
        .dcache_ready_i (dc_ready)
    );

    always #5 clk = ~clk;

    // Cache side request counter
    always @(posedge clk) begin
        if (rst) begin
            req_count <= 0;
        end else if (dc_req) begin
            req_count <= req_count + 1;
        end
    end

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %h, actual %h", cur_name, field, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("%s: ok", cur_name);
        end else begin
            $display("%s: %0d mismatches", cur_name, test_errors);
            tests_failed++;
        end
    endtask

    //////////////////////////////
    // Vector file
    //////////////////////////////

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        string       nm;
        logic [31:0] f [NCOL];
        num_vec = 0;
        fd = $fopen("tb/ex_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tb/ex_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            cnt = $fgets(line, fd);
            cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                          f[7], f[8], f[9], f[10], f[11], f[12]);
            if (cnt == NCOL + 1 && nm != "#") begin
                vec_name[num_vec] = nm;
                for (int k = 0; k < NCOL; k++) begin
                    vec_mem[num_vec][k] = f[k];
                end
                num_vec++;
            end
        end
        $fclose(fd);
        if (num_vec == 0) begin
            $display("the vector file holds no usable vectors");
            errors++;
        end
    endtask

    task automatic drive_vector(input int idx);
        in_valid <= 1'b1;
        in_op    <= ex_op_e'(vec_mem[idx][C_OP][5:0]);
        in_src1  <= vec_mem[idx][C_SRC1];
        in_src2  <= vec_mem[idx][C_SRC2];
        in_imm   <= vec_mem[idx][C_IMM];
        in_pc    <= vec_mem[idx][C_PC];
        in_waddr <= idx[4:0];
        in_wreg  <= ~idx[0];
        // Cache model goes busy for a random stretch
        if (vec_mem[idx][C_HOLD][0]) begin
            hold_left = ($random(seed) & 7) + 1;
            dc_ready <= 1'b0;
        end else begin
            hold_left = 0;
        end
    endtask

    task automatic check_vector(input int idx);
        int         waited;
        int         req_base;
        logic [5:0] op;
        bit         is_ld;
        bit         is_mem;
        mem_size_e  exp_size;
        cur_name = vec_name[idx];
        test_errors = 0;
        waited = 0;
        req_base = req_count;
        op = vec_mem[idx][C_OP][5:0];
        is_ld = op inside {OP_LD_B, OP_LD_H, OP_LD_W};
        is_mem = is_ld || (op inside {OP_ST_B, OP_ST_H, OP_ST_W});
        if (op inside {OP_LD_B, OP_ST_B}) begin
            exp_size = SIZE_B;
        end else if (op inside {OP_LD_H, OP_ST_H}) begin
            exp_size = SIZE_H;
        end else begin
            exp_size = SIZE_W;
        end
        while (hold_left > 0) begin
            check_value("in_ready while cache busy", 32'd0, in_ready);
            hold_left--;
            @(posedge clk);
            if (hold_left == 0) begin
                dc_ready <= 1'b1;
            end
            @(negedge clk);
            waited++;
            check_value("out_valid while waiting", 32'd0, out_valid);
        end
        while (!in_ready) begin
            if (waited >= TIMEOUT) begin
                $display("timeout: %s was not accepted within %0d cycles", cur_name, TIMEOUT);
                timed_out = 1'b1;
                tests_failed++;
                return;
            end
            @(posedge clk);
            @(negedge clk);
            waited++;
            check_value("out_valid while waiting", 32'd0, out_valid);
        end
        // Accept cycle
        if (op < 6'h10) begin
            check_value("accept delay", 32'd0, waited);
        end
        check_value("dcache_req", vec_mem[idx][C_REQ], dc_req);
        check_value("dcache_we", vec_mem[idx][C_WE], dc_we);
        check_value("dcache_addr", vec_mem[idx][C_ADDR], dc_addr);
        check_value("dcache_sel", vec_mem[idx][C_SEL], dc_sel);
        check_value("dcache_wdata", vec_mem[idx][C_CWDATA], dc_wdata);
        if (vec_mem[idx][C_REQ][0]) begin
            check_value("dcache_size", exp_size, dc_size);
        end
        @(posedge clk);
        if (idx + 1 < num_vec) begin
            drive_vector(idx + 1);
        end else begin
            in_valid <= 1'b0;
        end
        @(negedge clk);
        check_value("out_valid", 32'd1, out_valid);
        check_value("out_wdata", vec_mem[idx][C_WDATA], out_wdata);
        check_value("out_waddr", idx[4:0], out_waddr);
        check_value("out_wreg", {31'd0, ~idx[0]}, out_wreg);
        check_value("out_misalign", vec_mem[idx][C_MIS], out_misalign);
        check_value("out_data_ok", !is_ld, out_data_ok);
        if (is_mem) begin
            check_value("out_mem_addr", vec_mem[idx][C_SRC1] + vec_mem[idx][C_IMM],
                        out_mem_addr);
        end
        check_value("request count", vec_mem[idx][C_REQ], req_count - req_base);
        report_test();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int i;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_op = OP_NOP;
        in_src1 = '0;
        in_src2 = '0;
        in_imm = '0;
        in_pc = '0;
        in_waddr = '0;
        in_wreg = 1'b0;
        dc_ready = 1'b1;
        seed = 32'hdd11_3412;
        errors = 0;
        tests_failed = 0;
        hold_left = 0;
        timed_out = 1'b0;
        load_vectors();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Idle after reset
        cur_name = "reset_idle";
        test_errors = 0;
        repeat (3) begin
            @(negedge clk);
            check_value("out_valid", 32'd0, out_valid);
            check_value("dcache_req", 32'd0, dc_req);
        end
        report_test();
        if (num_vec > 0) begin
            @(posedge clk);
            drive_vector(0);
            @(negedge clk);
        end
        i = 0;
        while (i < num_vec && !timed_out) begin
            check_vector(i);
            i++;
        end
        if (!timed_out && num_vec > 0) begin
            cur_name = "tail";
            test_errors = 0;
            @(posedge clk);
            @(negedge clk);
            check_value("out_valid after last", 32'd0, out_valid);
            check_value("dcache_req after last", 32'd0, dc_req);
            report_test();
        end
        $display("%0d vectors, %0d failed tests, %0d mismatches", num_vec, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb/ex_stim.txt */
# test op src1 src2 imm pc | expected wdata misalign | req we addr sel cache_wdata | hold
# all hex; hold 1 makes the cache model go busy before the access
add        01 7fffffff 00000001 00000000 00000000 80000000 0 0 0 00000000 0 00000000 0
sub        02 00000005 00000007 00000000 00000000 fffffffe 0 0 0 00000000 0 00000000 0
slt        03 ffffffff 00000001 00000000 00000000 00000001 0 0 0 00000000 0 00000000 0
sltu       04 ffffffff 00000001 00000000 00000000 00000000 0 0 0 00000000 0 00000000 0
and        05 f0f0ff00 0ff0f0f0 00000000 00000000 00f0f000 0 0 0 00000000 0 00000000 0
or         06 f0f0ff00 0ff0f0f0 00000000 00000000 fff0fff0 0 0 0 00000000 0 00000000 0
xor        07 f0f0ff00 0ff0f0f0 00000000 00000000 ff000ff0 0 0 0 00000000 0 00000000 0
nor        08 f0f0ff00 0ff0f0f0 00000000 00000000 000f000f 0 0 0 00000000 0 00000000 0
sll        09 00000003 00000024 00000000 00000000 00000030 0 0 0 00000000 0 00000000 0
srl        0a 80000000 0000001f 00000000 00000000 00000001 0 0 0 00000000 0 00000000 0
sra        0b 80000000 00000004 00000000 00000000 f8000000 0 0 0 00000000 0 00000000 0
lui        0c 12345678 abcd0000 00000000 00000000 abcd0000 0 0 0 00000000 0 00000000 0
pcadd      0d 00000000 00002000 00000000 1c000100 1c002100 0 0 0 00000000 0 00000000 0
mul_lo     10 80000000 ffffffff 00000000 00000000 80000000 0 0 0 00000000 0 00000000 0
mulh_min   11 80000000 ffffffff 00000000 00000000 00000000 0 0 0 00000000 0 00000000 0
mulhu_min  12 80000000 ffffffff 00000000 00000000 7fffffff 0 0 0 00000000 0 00000000 0
mulh_neg   11 ffffffff 00000002 00000000 00000000 ffffffff 0 0 0 00000000 0 00000000 0
mulh_zero  11 80000000 00000000 00000000 00000000 00000000 0 0 0 00000000 0 00000000 0
mulhu_max  12 ffffffff ffffffff 00000000 00000000 fffffffe 0 0 0 00000000 0 00000000 0
div_neg    18 fffffff9 00000002 00000000 00000000 fffffffd 0 0 0 00000000 0 00000000 0
mod_neg    1a fffffff9 00000002 00000000 00000000 ffffffff 0 0 0 00000000 0 00000000 0
divu       19 fffffff9 00000002 00000000 00000000 7ffffffc 0 0 0 00000000 0 00000000 0
modu       1b fffffff9 00000002 00000000 00000000 00000001 0 0 0 00000000 0 00000000 0
mod_negdsr 1a 00000007 fffffffe 00000000 00000000 00000001 0 0 0 00000000 0 00000000 0
div_ovf    18 80000000 ffffffff 00000000 00000000 80000000 0 0 0 00000000 0 00000000 0
mod_ovf    1a 80000000 ffffffff 00000000 00000000 00000000 0 0 0 00000000 0 00000000 0
div_zero   18 fffffffb 00000000 00000000 00000000 fffffffb 0 0 0 00000000 0 00000000 0
mod_zero   1a fffffffb 00000000 00000000 00000000 00000000 0 0 0 00000000 0 00000000 0
ld_w       22 00001000 00000000 00000004 00000000 00001004 0 1 0 00001004 f 00000000 0
ld_b       20 00001000 00000000 00000003 00000000 00001003 0 1 0 00001003 8 00000000 0
ld_h       21 00002000 00000000 00000002 00000000 00002002 0 1 0 00002002 c 00000000 0
st_b_hold  28 00003000 aabbccdd 00000001 00000000 00003001 0 1 1 00003001 2 0000dd00 1
st_h_same  29 00003000 11223344 00000002 00000000 00003002 0 1 1 00003002 c 33440000 0
st_w_hold  2a 00004000 deadbeef fffffffc 00000000 00003ffc 0 1 1 00003ffc f deadbeef 1
st_w_same  2a 00003ff0 01020304 00000008 00000000 00003ff8 0 1 1 00003ff8 f 01020304 0
ld_b_hold  20 00005000 00000000 00000000 00000000 00005000 0 1 0 00005000 1 00000000 1
mis_ld_h   21 00001001 00000000 00000000 00000000 00001001 1 0 0 00000000 0 00000000 0
mis_st_w   2a 00001002 ffffffff 00000000 00000000 00001002 1 0 0 00000000 0 00000000 0

/* sources.f */
+incdir+include
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mul_unit.sv
verilog/ex_div_unit.sv
verilog/ex_mem_req.sv
verilog/ex_stage.sv
tb/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/ex_pkg.sv
      - verilog/ex_alu.sv
      - verilog/ex_mul_unit.sv
      - verilog/ex_div_unit.sv
      - verilog/ex_mem_req.sv
      - verilog/ex_stage.sv
  - target: simulation
    files:
      - tb/ex_stage_tb.sv
